// ==== build.f ====
hdl/core_mem_pkg.sv
hdl/dcache_if_pkg.sv
hdl/amo_alu.sv
hdl/dmem_scratchpad.sv
hdl/mem_unit.sv
hdl/mem_stage_top.sv
tb/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage \
    -f build.f -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb/tb_mem_stage.sv ====
/* memory stage testbench: directed load/store, AMO, LR/SC, misaligned,
   I/O and kill tests against a byte-level reference model */

module tb_mem_stage import core_mem_pkg::*, dcache_if_pkg::*; ();

    localparam logic [63:0] DMEM_BASE      = 64'h8000_0000;
    localparam int          TIMEOUT_CYCLES = 3000;  // ~200 ops of up to 4 cycles plus margin

    logic       clk_i;
    logic       rstn_i;
    logic       valid_i;
    logic       kill_i;
    logic       csr_eret_i;
    mem_issue_t issue_i;
    logic       ready_o;
    logic       lock_o;
    logic       io_wr_o;
    logic       xcpt_ma_o;
    bus64_t     data_o;
    bus64_t     io_data_o;
    reg_t       wb_rd_o;

    logic [7:0]  ref_mem [DMEM_WORDS*8];   // byte-level reference memory
    logic        resv_valid;
    logic [4:0]  resv_word;
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          test_errs;
    int          cycle_count;

    // what the last operation showed
    logic   seen_ready, seen_lock, seen_xcpt, seen_io_wr;
    bus64_t resp_data, io_value;
    reg_t   resp_rd;

    instr_t store_kinds [4] = '{SB, SH, SW, SD};
    instr_t load_kinds  [7] = '{LB, LBU, LH, LHU, LW, LWU, LD};
    instr_t mis_kinds   [6] = '{LH, LW, LD, SH, SW, SD};
    instr_t amo_w_kinds [9] = '{AMO_SWAPW, AMO_ADDW, AMO_XORW, AMO_ANDW, AMO_ORW,
                                AMO_MINW, AMO_MAXW, AMO_MINWU, AMO_MAXWU};
    instr_t amo_d_kinds [9] = '{AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
                                AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU};

    mem_stage_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------
    // random bits, model and checks

    function automatic bus64_t take_bits(input int n);
        bus64_t v;
        logic   fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic bus64_t word_addr(input int w, input int off);
        return DMEM_BASE + 64'(w * 8 + off);
    endfunction

    function automatic int access_bytes(input instr_t instr);
        case (instr)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic bus64_t model_read(input bus64_t addr, input int nbytes, input logic uns);
        bus64_t     v;
        logic [7:0] b;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            b = addr[7:0] + 8'(i);   // wraps like the scratchpad index
            v[i*8 +: 8] = ref_mem[b];
        end
        if (!uns && nbytes < 8 && v[nbytes*8-1]) begin
            v = v | (~64'h0 << (nbytes * 8));
        end
        return v;
    endfunction

    function automatic void model_write(input bus64_t addr, input int nbytes, input bus64_t data);
        logic [7:0] b;
        for (int i = 0; i < nbytes; i++) begin
            b = addr[7:0] + 8'(i);
            ref_mem[b] = data[i*8 +: 8];
        end
        if (addr[7:3] == resv_word) begin
            resv_valid = 1'b0;   // any write to the reserved word
        end
    endfunction

    function automatic bus64_t amo_result(input int k, input bus64_t a, input bus64_t b,
                                          input logic word);
        bus64_t r;
        logic   lt_s;
        logic   lt_u;
        if (word) begin
            lt_s = $signed(a[31:0]) < $signed(b[31:0]);
            lt_u = a[31:0] < b[31:0];
        end else begin
            lt_s = $signed(a) < $signed(b);
            lt_u = a < b;
        end
        case (k)
            0:       r = b;
            1:       r = a + b;
            2:       r = a ^ b;
            3:       r = a & b;
            4:       r = a | b;
            5:       r = lt_s ? a : b;
            6:       r = lt_s ? b : a;
            7:       r = lt_u ? a : b;
            default: r = lt_u ? b : a;
        endcase
        return r;
    endfunction

    task automatic check_value(input bus64_t got, input bus64_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAIL t=%0t %s", $time, what);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-14s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // --------------------
    // operation helpers

    task automatic run_op(input instr_t instr, input bus64_t addr, input bus64_t data,
                          input reg_t rd, input logic kill);
        bus64_t imm;
        logic   is_amo;
        logic   busy;
        imm    = take_bits(6);
        is_amo = !(instr inside {LB, LBU, LH, LHU, LW, LWU, LD, SB, SH, SW, SD});
        @(negedge clk_i);
        issue_i.instr = instr;
        issue_i.imm   = imm;
        issue_i.rs1   = is_amo ? addr : addr - imm;   // amo address ignores imm
        issue_i.rs2   = data;
        issue_i.rd    = rd;
        valid_i       = 1'b1;
        kill_i        = kill;
        seen_ready    = 1'b0;
        seen_lock     = 1'b0;
        seen_xcpt     = 1'b0;
        seen_io_wr    = 1'b0;
        busy          = 1'b1;
        while (busy) begin
            @(negedge clk_i);
            if (ready_o) begin
                seen_ready = 1'b1;
                resp_data  = data_o;
                resp_rd    = wb_rd_o;
            end
            if (xcpt_ma_o) seen_xcpt = 1'b1;
            if (io_wr_o) begin
                seen_io_wr = 1'b1;
                io_value   = io_data_o;
            end
            if (lock_o) seen_lock = 1'b1;
            else        busy = 1'b0;
        end
        valid_i = 1'b0;
        kill_i  = 1'b0;
    endtask

    task automatic load_check(input instr_t instr, input bus64_t addr);
        bus64_t exp;
        reg_t   rd;
        rd  = 5'(take_bits(5));
        exp = model_read(addr, access_bytes(instr), instr inside {LBU, LHU, LWU});
        run_op(instr, addr, 64'h0, rd, 1'b0);
        check_flag(seen_ready, "no ready_o pulse for a load");
        check_value(resp_data, exp, $sformatf("%s at %h", instr.name(), addr));
        check_value(64'(resp_rd), 64'(rd), "wb_rd_o");
    endtask

    task automatic store_op(input instr_t instr, input bus64_t addr, input bus64_t data);
        run_op(instr, addr, data, 5'(take_bits(5)), 1'b0);
        model_write(addr, access_bytes(instr), data);
        check_flag(!seen_ready, "ready_o pulsed for a store");
    endtask

    task automatic amo_check(input int k, input logic word);
        instr_t ins;
        int     n;
        bus64_t addr, opnd, old, new_val;
        reg_t   rd;
        ins  = word ? amo_w_kinds[k] : amo_d_kinds[k];
        n    = word ? 4 : 8;
        addr = word_addr(int'(take_bits(5)), word ? 4 * int'(take_bits(1)) : 0);
        opnd = take_bits(64);
        rd   = 5'(take_bits(5));
        old  = model_read(addr, n, 1'b0);
        if (k >= 5 && word)  opnd[31] = ~old[31];   // signed and unsigned order differ
        if (k >= 5 && !word) opnd[63] = ~old[63];
        new_val = amo_result(k, old, opnd, word);
        run_op(ins, addr, opnd, rd, 1'b0);
        model_write(addr, n, new_val);
        check_flag(seen_ready, "no ready_o pulse for an AMO");
        check_value(resp_data, old, $sformatf("%s old value", ins.name()));
        check_value(64'(resp_rd), 64'(rd), "wb_rd_o");
        load_check(LD, {addr[63:3], 3'b000});   // other half must stay intact
    endtask

    task automatic lr_check(input instr_t ins, input bus64_t addr, input logic word);
        bus64_t exp;
        exp = model_read(addr, word ? 4 : 8, 1'b0);
        run_op(ins, addr, 64'h0, 5'(take_bits(5)), 1'b0);
        resv_valid = 1'b1;
        resv_word  = addr[7:3];
        check_flag(seen_ready, "no ready_o pulse for lr");
        check_value(resp_data, exp, $sformatf("%s value", ins.name()));
    endtask

    task automatic sc_check(input instr_t ins, input bus64_t addr, input logic word);
        bus64_t d;
        logic   ok;
        d  = take_bits(64);
        ok = resv_valid && (resv_word == addr[7:3]);
        run_op(ins, addr, d, 5'(take_bits(5)), 1'b0);
        if (ok) model_write(addr, word ? 4 : 8, d);
        resv_valid = 1'b0;   // sc consumes the reservation either way
        check_flag(seen_ready, "no ready_o pulse for sc");
        check_value(resp_data, ok ? 64'd0 : 64'd1, $sformatf("%s result", ins.name()));
        load_check(LD, {addr[63:3], 3'b000});
    endtask

    // --------------------
    // tests

    task automatic fill_memory();
        for (int w = 0; w < DMEM_WORDS; w++) begin
            store_op(SD, word_addr(w, 0), take_bits(64));
        end
        report_test("fill");
    endtask

    task automatic test_loads_stores();
        instr_t st;
        int     w;
        int     off;
        repeat (12) begin
            st  = store_kinds[2'(take_bits(2))];
            w   = int'(take_bits(5));
            off = int'(take_bits(3)) & ~(access_bytes(st) - 1);
            store_op(st, word_addr(w, off), take_bits(64));
            for (int k = 0; k < 7; k++) begin
                off = int'(take_bits(3)) & ~(access_bytes(load_kinds[k]) - 1);
                load_check(load_kinds[k], word_addr(w, off));
            end
        end
        report_test("loads_stores");
    endtask

    task automatic test_amos();
        for (int k = 0; k < 9; k++) begin
            amo_check(k, 1'b1);
            amo_check(k, 1'b0);
        end
        report_test("amo");
    endtask

    task automatic test_lr_sc();
        bus64_t a;
        a = word_addr(int'(take_bits(5)), 0);
        lr_check(AMO_LRD, a, 1'b0);
        sc_check(AMO_SCD, a, 1'b0);      // reservation held
        sc_check(AMO_SCD, a, 1'b0);      // reservation already used
        a = word_addr(int'(take_bits(5)), 4);
        lr_check(AMO_LRW, a, 1'b1);
        @(negedge clk_i);
        csr_eret_i = 1'b1;               // eret drops the reservation
        @(negedge clk_i);
        csr_eret_i = 1'b0;
        resv_valid = 1'b0;
        sc_check(AMO_SCW, a, 1'b1);
        report_test("lr_sc");
    endtask

    task automatic test_misaligned();
        int w;
        int off;
        for (int k = 0; k < 6; k++) begin
            w   = int'(take_bits(5));
            off = int'(take_bits(3));
            if (off % access_bytes(mis_kinds[k]) == 0) off++;
            run_op(mis_kinds[k], word_addr(w, off), take_bits(64), 5'(take_bits(5)), 1'b0);
            check_flag(seen_xcpt, "xcpt_ma_o not raised for a misaligned access");
            check_flag(!seen_ready, "ready_o pulsed for a misaligned access");
            load_check(LD, word_addr(w, 0));
        end
        report_test("misaligned");
    endtask

    task automatic test_io_store();
        bus64_t d;
        bus64_t a;
        for (int k = 0; k < 2; k++) begin
            a = IO_BASE_ADDR + (k == 0 ? 64'h0 : 64'h48);
            d = take_bits(64);
            run_op(SD, a, d, 5'(take_bits(5)), 1'b0);
            check_flag(seen_io_wr, "io_wr_o did not pulse for an I/O store");
            check_value(io_value, d, "io_data_o");
            check_flag(!seen_ready, "ready_o pulsed for an I/O store");
            load_check(LD, word_addr(int'(a[7:3]), 0));   // aliased word untouched
        end
        report_test("io_store");
    endtask

    task automatic test_kill();
        bus64_t a;
        a = word_addr(int'(take_bits(5)), 0);
        for (int k = 0; k < 2; k++) begin
            run_op(k == 0 ? SD : LD, a, take_bits(64), 5'(take_bits(5)), 1'b1);
            repeat (2) begin
                @(negedge clk_i);
                if (ready_o) seen_ready = 1'b1;   // a late response shows here
            end
            check_flag(!seen_lock, "lock_o rose for a killed request");
            check_flag(!seen_ready, "a killed request got a response");
        end
        load_check(LD, a);
        report_test("kill");
    endtask

    // --------------------
    // main sequence and watchdog

    initial begin
        rstn_i     = 1'b0;
        valid_i    = 1'b0;
        kill_i     = 1'b0;
        csr_eret_i = 1'b0;
        issue_i    = '0;
        lfsr_q     = 32'ha6f6;
        resv_valid = 1'b0;
        resv_word  = '0;
        errors     = 0;
        checks     = 0;
        test_errs  = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (2) @(negedge clk_i);
        check_flag(!lock_o && !ready_o && !io_wr_o, "outputs not idle after reset");

        fill_memory();
        test_loads_stores();
        test_amos();
        test_lr_sc();
        test_misaligned();
        test_io_store();
        test_kill();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== hdl/mem_stage_top.sv ====
/* memory stage top: request sequencer and data scratchpad */

module mem_stage_top import core_mem_pkg::*, dcache_if_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       valid_i,
    input  logic       kill_i,
    input  logic       csr_eret_i,
    input  mem_issue_t issue_i,
    output logic       ready_o,
    output logic       lock_o,
    output logic       io_wr_o,
    output bus64_t     data_o,
    output bus64_t     io_data_o,
    output reg_t       wb_rd_o,
    output logic       xcpt_ma_o
);

    dcache_req_t  dmem_req;
    dcache_resp_t dmem_resp;
    logic         dmem_req_ready;

    mem_unit u_mem_unit (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .valid_i          (valid_i),
        .kill_i           (kill_i),
        .csr_eret_i       (csr_eret_i),
        .issue_i          (issue_i),
        .dmem_req_ready_i (dmem_req_ready),
        .dmem_resp_i      (dmem_resp),
        .dmem_req_o       (dmem_req),
        .ready_o          (ready_o),
        .lock_o           (lock_o),
        .data_o           (data_o),
        .wb_rd_o          (wb_rd_o)
    );

    dmem_scratchpad u_dmem (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dmem_req_i       (dmem_req),
        .dmem_req_ready_o (dmem_req_ready),
        .dmem_resp_o      (dmem_resp),
        .io_wr_o          (io_wr_o),
        .io_data_o        (io_data_o)
    );

    assign xcpt_ma_o = dmem_resp.xcpt_ma_ld | dmem_resp.xcpt_ma_st;

endmodule

// ==== hdl/mem_unit.sv ====
/* load/store/amo request sequencer: FSM, command decode,
   address generation and writeback outputs */

module mem_unit import core_mem_pkg::*, dcache_if_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         valid_i,
    input  logic         kill_i,
    input  logic         csr_eret_i,
    input  mem_issue_t   issue_i,
    input  logic         dmem_req_ready_i,
    input  dcache_resp_t dmem_resp_i,
    output dcache_req_t  dmem_req_o,
    output logic         ready_o,
    output logic         lock_o,
    output bus64_t       data_o,
    output reg_t         wb_rd_o
);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_IDLE,
        ST_MAKE_REQ,
        ST_WAIT_RESP
    } state_t;

    state_t      state_q;
    state_t      state_d;
    dcache_cmd_t req_cmd;
    mem_size_t   req_size;
    mem_op_t     mem_op;
    logic        req_valid;
    logic        mem_xcpt;
    logic        io_store;

    // --------------------
    // decode
    always_comb begin
        case (issue_i.instr)
            AMO_LRW, AMO_LRD:     req_cmd = DCMD_LR;
            AMO_SCW, AMO_SCD:     req_cmd = DCMD_SC;
            AMO_SWAPW, AMO_SWAPD: req_cmd = DCMD_SWAP;
            AMO_ADDW, AMO_ADDD:   req_cmd = DCMD_ADD;
            AMO_XORW, AMO_XORD:   req_cmd = DCMD_XOR;
            AMO_ANDW, AMO_ANDD:   req_cmd = DCMD_AND;
            AMO_ORW, AMO_ORD:     req_cmd = DCMD_OR;
            AMO_MINW, AMO_MIND:   req_cmd = DCMD_MIN;
            AMO_MAXW, AMO_MAXD:   req_cmd = DCMD_MAX;
            AMO_MINWU, AMO_MINDU: req_cmd = DCMD_MINU;
            AMO_MAXWU, AMO_MAXDU: req_cmd = DCMD_MAXU;
            SB, SH, SW, SD:       req_cmd = DCMD_STORE;
            default:              req_cmd = DCMD_LOAD;
        endcase
    end

    always_comb begin
        case (issue_i.instr)
            LB, LBU, SB: req_size = SIZE_B;
            LH, LHU, SH: req_size = SIZE_H;
            LD, SD, AMO_LRD, AMO_SCD, AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD,
            AMO_ORD, AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU:
                         req_size = SIZE_D;
            default:     req_size = SIZE_W;   // word loads/stores and W amos
        endcase
    end

    assign mem_op = (req_cmd == DCMD_LOAD)  ? MEM_LOAD  :
                    (req_cmd == DCMD_STORE) ? MEM_STORE : MEM_AMO;

    // --------------------
    // request
    assign dmem_req_o.valid         = req_valid;
    assign dmem_req_o.kill          = mem_xcpt | kill_i;
    assign dmem_req_o.invalidate_lr = csr_eret_i;
    assign dmem_req_o.cmd           = req_cmd;
    assign dmem_req_o.addr          = (mem_op == MEM_AMO) ? issue_i.rs1
                                                          : issue_i.rs1 + issue_i.imm;
    assign dmem_req_o.size          = req_size;
    assign dmem_req_o.is_unsigned   = issue_i.instr inside {LBU, LHU, LWU};
    assign dmem_req_o.data          = issue_i.rs2;
    assign dmem_req_o.tag           = {2'b00, issue_i.rd, 1'b0};

    assign mem_xcpt = dmem_resp_i.xcpt_ma_ld | dmem_resp_i.xcpt_ma_st;
    assign io_store = (mem_op == MEM_STORE) & in_io_window(dmem_req_o.addr);  // no response

    // --------------------
    // sequencing FSM
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        req_valid = 1'b0;
        lock_o    = 1'b0;
        state_d   = state_q;
        case (state_q)
            ST_RESET: state_d = ST_IDLE;
            ST_IDLE: begin
                req_valid = valid_i & ~kill_i & dmem_req_ready_i;
                lock_o    = valid_i & ~kill_i;
                if (req_valid) begin
                    state_d = ST_MAKE_REQ;
                end
            end
            ST_MAKE_REQ: begin
                lock_o  = ~kill_i;
                state_d = kill_i ? ST_IDLE : ST_WAIT_RESP;
            end
            ST_WAIT_RESP: begin
                // response, exception or i/o store all end the wait
                if (dmem_resp_i.valid | mem_xcpt | io_store | kill_i) begin
                    state_d = ST_IDLE;
                end else begin
                    lock_o = 1'b1;
                end
            end
            default: state_d = ST_RESET;
        endcase
    end

    // writeback
    assign ready_o = dmem_resp_i.valid & (mem_op != MEM_STORE);
    assign data_o  = dmem_resp_i.data;
    assign wb_rd_o = dmem_resp_i.tag[5:1];

endmodule

// ==== hdl/dmem_scratchpad.sv ====
/* data scratchpad: word storage, byte lanes, load formatting, LR reservation,
   misalignment check, I/O output register and two-cycle response */

module dmem_scratchpad import core_mem_pkg::*, dcache_if_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  dcache_req_t  dmem_req_i,
    output logic         dmem_req_ready_o,
    output dcache_resp_t dmem_resp_o,
    output logic         io_wr_o,
    output bus64_t       io_data_o
);

    bus64_t                mem_q [DMEM_WORDS];
    dcache_req_t           req_q;
    logic                  s1_valid_q;
    logic                  resp_valid_q;
    bus64_t                resp_data_q;
    logic [7:0]            resp_tag_q;
    logic                  resv_valid_q;
    logic [DMEM_IDX_W-1:0] resv_idx_q;
    logic                  io_wr_q;
    bus64_t                io_data_q;

    logic                  accept;
    logic                  misaligned;
    logic                  live_is_load;
    logic [DMEM_IDX_W-1:0] idx;
    logic [2:0]            offs;
    logic                  is_store, is_lr, is_sc, is_amo, io_store;
    logic                  s1_fire, sc_ok, mem_we;
    logic [7:0]            byte_en;
    bus64_t                old_word, shifted, load_val, alu_res, src_data;
    bus64_t                lane_data, wr_mask;

    // --------------------
    // request side
    assign dmem_req_ready_o = ~s1_valid_q;   // busy while the access runs
    assign accept = dmem_req_i.valid & dmem_req_ready_o & ~dmem_req_i.kill;

    always_comb begin
        case (dmem_req_i.size)
            SIZE_B:  misaligned = 1'b0;
            SIZE_H:  misaligned = dmem_req_i.addr[0];
            SIZE_W:  misaligned = |dmem_req_i.addr[1:0];
            default: misaligned = |dmem_req_i.addr[2:0];
        endcase
    end

    assign live_is_load = (dmem_req_i.cmd == DCMD_LOAD) | (dmem_req_i.cmd == DCMD_LR);

    // --------------------
    // access stage
    assign idx      = req_q.addr[3 +: DMEM_IDX_W];  // wraps modulo memory size
    assign offs     = req_q.addr[2:0];
    assign is_store = req_q.cmd == DCMD_STORE;
    assign is_lr    = req_q.cmd == DCMD_LR;
    assign is_sc    = req_q.cmd == DCMD_SC;
    assign is_amo   = ~(is_store | is_lr | is_sc | (req_q.cmd == DCMD_LOAD));
    assign io_store = is_store & in_io_window(req_q.addr);
    assign s1_fire  = s1_valid_q & ~io_store;
    assign sc_ok    = resv_valid_q & (resv_idx_q == idx);
    assign mem_we   = s1_fire & (is_store | is_amo | (is_sc & sc_ok));

    assign old_word = mem_q[idx];
    assign shifted  = old_word >> {offs, 3'b000};

    amo_alu u_amo_alu (
        .cmd_i     (req_q.cmd),
        .word_i    (req_q.size == SIZE_W),
        .mem_val_i (shifted),
        .operand_i (req_q.data),
        .result_o  (alu_res)
    );

    assign src_data = is_amo ? alu_res : req_q.data;

    always_comb begin
        case (req_q.size)
            SIZE_B: begin
                lane_data = {8{src_data[7:0]}};
                byte_en   = 8'h01 << offs;
                load_val  = req_q.is_unsigned ? {56'b0, shifted[7:0]}
                                              : {{56{shifted[7]}}, shifted[7:0]};
            end
            SIZE_H: begin
                lane_data = {4{src_data[15:0]}};
                byte_en   = 8'h03 << offs;
                load_val  = req_q.is_unsigned ? {48'b0, shifted[15:0]}
                                              : {{48{shifted[15]}}, shifted[15:0]};
            end
            SIZE_W: begin
                lane_data = {2{src_data[31:0]}};
                byte_en   = 8'h0f << offs;
                load_val  = req_q.is_unsigned ? {32'b0, shifted[31:0]}
                                              : {{32{shifted[31]}}, shifted[31:0]};
            end
            default: begin
                lane_data = src_data;
                byte_en   = 8'hff;
                load_val  = shifted;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            wr_mask[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    // --------------------
    // registers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q   <= 1'b0;
            resp_valid_q <= 1'b0;
            io_wr_q      <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            s1_valid_q   <= accept;
            resp_valid_q <= s1_fire;
            io_wr_q      <= accept & (dmem_req_i.cmd == DCMD_STORE)
                                   & in_io_window(dmem_req_i.addr);
            if (s1_fire & is_lr) begin
                resv_valid_q <= 1'b1;
            end else if (s1_fire & (is_sc | (mem_we & (idx == resv_idx_q)))) begin
                resv_valid_q <= 1'b0;   // sc always consumes it
            end
            if (dmem_req_i.invalidate_lr) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= dmem_req_i;
        end
        if (accept & (dmem_req_i.cmd == DCMD_STORE) & in_io_window(dmem_req_i.addr)) begin
            io_data_q <= dmem_req_i.data;
        end
        if (mem_we) begin
            mem_q[idx] <= (old_word & ~wr_mask) | (lane_data & wr_mask);
        end
        if (s1_fire & is_lr) begin
            resv_idx_q <= idx;
        end
        resp_data_q <= is_sc ? {63'b0, ~sc_ok} : load_val;  // sc: 0 on success
        resp_tag_q  <= req_q.tag;
    end

    // --------------------
    // outputs
    assign dmem_resp_o.valid      = resp_valid_q;
    assign dmem_resp_o.data       = resp_data_q;
    assign dmem_resp_o.tag        = resp_tag_q;
    assign dmem_resp_o.xcpt_ma_ld = misaligned & live_is_load;
    assign dmem_resp_o.xcpt_ma_st = misaligned & ~live_is_load;

    assign io_wr_o   = io_wr_q;
    assign io_data_o = io_data_q;

endmodule

// ==== hdl/amo_alu.sv ====
/* read-modify-write arithmetic for atomic memory commands */

module amo_alu import core_mem_pkg::*, dcache_if_pkg::*; (
    input  dcache_cmd_t cmd_i,
    input  logic        word_i,     // W form
    input  bus64_t      mem_val_i,
    input  bus64_t      operand_i,
    output bus64_t      result_o
);

    bus64_t op_a;
    bus64_t op_b;
    bus64_t res;
    logic   lt_s;
    logic   lt_u;

    // sign extension keeps the unsigned order of 32-bit values too
    assign op_a = word_i ? {{32{mem_val_i[31]}}, mem_val_i[31:0]} : mem_val_i;
    assign op_b = word_i ? {{32{operand_i[31]}}, operand_i[31:0]} : operand_i;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (cmd_i)
            DCMD_SWAP: res = op_b;
            DCMD_ADD:  res = op_a + op_b;
            DCMD_XOR:  res = op_a ^ op_b;
            DCMD_AND:  res = op_a & op_b;
            DCMD_OR:   res = op_a | op_b;
            DCMD_MIN:  res = lt_s ? op_a : op_b;
            DCMD_MAX:  res = lt_s ? op_b : op_a;
            DCMD_MINU: res = lt_u ? op_a : op_b;
            DCMD_MAXU: res = lt_u ? op_b : op_a;
            default:   res = op_a;    // not an amo, memory unchanged
        endcase
    end

    // only the low half is stored for W forms
    assign result_o = word_i ? {{32{res[31]}}, res[31:0]} : res;

endmodule

// ==== hdl/dcache_if_pkg.sv ====
/* data-memory interface: command and size encodings, request and
   response structs, scratchpad size and the I/O window */

package dcache_if_pkg;

    localparam int          DMEM_WORDS   = 32;
    localparam int          DMEM_IDX_W   = $clog2(DMEM_WORDS);
    localparam logic [63:0] IO_BASE_ADDR = 64'h8002_0000;
    localparam logic [63:0] IO_LAST_ADDR = 64'h8002_0053;

    typedef enum logic [4:0] {
        DCMD_LOAD  = 5'b00000,
        DCMD_STORE = 5'b00001,
        DCMD_SWAP  = 5'b00100,
        DCMD_LR    = 5'b00110,
        DCMD_SC    = 5'b00111,
        DCMD_ADD   = 5'b01000,
        DCMD_XOR   = 5'b01001,
        DCMD_OR    = 5'b01010,
        DCMD_AND   = 5'b01011,
        DCMD_MIN   = 5'b01100,
        DCMD_MAX   = 5'b01101,
        DCMD_MINU  = 5'b01110,
        DCMD_MAXU  = 5'b01111
    } dcache_cmd_t;

    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_D} mem_size_t;

    // tag layout: rd in bits 5:1, bit 0 is 0 (integer destination)
    typedef struct packed {
        logic        valid;
        logic        kill;
        logic        invalidate_lr;
        dcache_cmd_t cmd;
        logic [63:0] addr;
        mem_size_t   size;
        logic        is_unsigned;
        logic [63:0] data;
        logic [7:0]  tag;
    } dcache_req_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
        logic [7:0]  tag;
        logic        xcpt_ma_ld;
        logic        xcpt_ma_st;
    } dcache_resp_t;

    function automatic logic in_io_window(input logic [63:0] addr);
        return (addr >= IO_BASE_ADDR) && (addr <= IO_LAST_ADDR);
    endfunction

endpackage

// ==== hdl/core_mem_pkg.sv ====
/* core-side memory stage types: data words, register index,
   instruction kinds, memory-op classes and the issue struct */

package core_mem_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] bus64_t;
    typedef logic [4:0]      reg_t;

    // memory instructions seen by the stage
    typedef enum logic [5:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD,
        AMO_LRW,   AMO_LRD,
        AMO_SCW,   AMO_SCD,
        AMO_SWAPW, AMO_SWAPD,
        AMO_ADDW,  AMO_ADDD,
        AMO_XORW,  AMO_XORD,
        AMO_ANDW,  AMO_ANDD,
        AMO_ORW,   AMO_ORD,
        AMO_MINW,  AMO_MIND,
        AMO_MAXW,  AMO_MAXD,
        AMO_MINWU, AMO_MINDU,
        AMO_MAXWU, AMO_MAXDU
    } instr_t;

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_AMO     // lr/sc and all read-modify-write ops
    } mem_op_t;

    // one issued memory instruction
    typedef struct packed {
        instr_t instr;
        bus64_t rs1;
        bus64_t rs2;    // store data or amo operand
        bus64_t imm;
        reg_t   rd;
    } mem_issue_t;

endpackage
